//--- Backend.f
+incdir+verilog
verilog/BackendPkg.sv
verilog/BackendIfs.sv
verilog/Decode.sv
verilog/Rename.sv
verilog/ROB.sv
verilog/Execute.sv
verilog/Backend.sv
tb/Backend_assert.sv
tb/BackendTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f Backend.f --top-module BackendTb -o simBackend

output=$(./obj_dir/simBackend 2>&1) || true
echo "$output"

if echo "$output" | grep -q "^Regression passed$"; then
    exit 0
fi
exit 1

//--- tb/BackendTb.sv
`timescale 1ns/1ps
`include "backend_cfg.svh"

module BackendTb;
    localparam int CLK_PERIOD = 100;
    localparam int RESET_CYCLES = 10;
    localparam int QUIET_CYCLES = 20;
    localparam int ADDI_COUNT = 100;
    localparam int RTYPE_COUNT = 300;
    localparam int CHAIN_COUNT = 100;
    localparam int BURST_COUNT = 150;
    localparam int TOTAL_INSTS = ADDI_COUNT + RTYPE_COUNT + CHAIN_COUNT + BURST_COUNT;
    localparam int TIMEOUT_CYCLES = 20 * TOTAL_INSTS + 200;
    localparam int DRAIN_CYCLES = 10 * `ROB_SIZE; // Far above the deepest possible backlog

    logic clk = 1'b0;
    logic reset;
    logic fetchValid;
    BackendPkg::InstWord fetchInst;
    logic stall;
    logic commitValid;
    BackendPkg::ArchIdx commitArchReg;
    logic [`XLEN-1:0] commitValue;

    string testName;
    BackendPkg::InstWord pending [$]; // Accepted in program order, not yet committed
    logic [`XLEN-1:0] archRegs [`ARCH_REGS];
    int acceptedCount;
    int commitCount;

    Backend i_Backend (
        .clk(clk),
        .reset(reset),
        .fetchValid(fetchValid),
        .fetchInst(fetchInst),
        .stall(stall),
        .commitValid(commitValid),
        .commitArchReg(commitArchReg),
        .commitValue(commitValue)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic checkEqual(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH test=%s check=%s expected=%h actual=%h",
                     testName, what, expected, actual);
            $display("Regression failed");
            $fatal(1, "Stopping at first error");
        end
    endtask

    function automatic BackendPkg::ArchIdx randReg();
        return BackendPkg::ArchIdx'($urandom % `ARCH_REGS);
    endfunction

    function automatic BackendPkg::InstWord makeRType(input BackendPkg::ArchIdx rd,
                                                      input BackendPkg::ArchIdx rs1,
                                                      input BackendPkg::ArchIdx rs2);
        BackendPkg::InstWord word;
        word = '0;
        word.r.opcode = BackendPkg::OpCode'(4'($urandom % 5)); // ADD through XOR
        word.r.rd = rd;
        word.r.rs1 = rs1;
        word.r.rs2 = rs2;
        return word;
    endfunction

    function automatic BackendPkg::InstWord makeAddi(input BackendPkg::ArchIdx rd,
                                                     input BackendPkg::ArchIdx rs1,
                                                     input logic [11:0] imm12);
        BackendPkg::InstWord word;
        word = '0;
        word.i.opcode = BackendPkg::OP_ADDI;
        word.i.rd = rd;
        word.i.rs1 = rs1;
        word.i.imm12 = imm12;
        return word;
    endfunction

    // ======================================================================
    // Reference model
    // ======================================================================

    function automatic logic [`XLEN-1:0] modelResult(input BackendPkg::InstWord word);
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] result;
        a = archRegs[word.r.rs1];
        if (word.r.opcode == BackendPkg::OP_ADDI) begin
            b = int'($signed(word.i.imm12));
        end else begin
            b = archRegs[word.r.rs2];
        end
        case (word.r.opcode)
            BackendPkg::OP_SUB: result = a - b;
            BackendPkg::OP_AND: result = a & b;
            BackendPkg::OP_OR:  result = a | b;
            BackendPkg::OP_XOR: result = a ^ b;
            default:            result = a + b; // ADD and ADDI
        endcase
        return result;
    endfunction

    always @(negedge clk) begin : commitMonitor
        BackendPkg::InstWord retired;
        logic [`XLEN-1:0] expValue;
        if (!reset && commitValid) begin
            if (pending.size() == 0) begin
                $display("A commit appeared with no accepted instruction outstanding");
                $display("Regression failed");
                $fatal(1, "Stopping at first error");
            end else begin
                retired = pending.pop_front();
                expValue = modelResult(retired);
                archRegs[retired.r.rd] = expValue;
                checkEqual("commitArchReg", retired.r.rd, commitArchReg);
                checkEqual("commitValue", expValue, commitValue);
                commitCount++;
            end
        end
    end

    // ======================================================================
    // Drivers
    // ======================================================================

    task automatic sendInst(input BackendPkg::InstWord word);
        fetchValid <= 1'b1;
        fetchInst  <= word;
        @(negedge clk);
        while (stall) begin
            @(negedge clk);
        end
        @(posedge clk);
        pending.push_back(word);
        acceptedCount++;
    endtask

    task automatic idleGap();
        int cycles;
        cycles = $urandom % 3;
        if (cycles != 0) begin
            fetchValid <= 1'b0;
            repeat (cycles) @(posedge clk);
        end
    endtask

    task automatic drainPipeline();
        int waited;
        waited = 0;
        fetchValid <= 1'b0;
        while (pending.size() != 0 && waited < DRAIN_CYCLES) begin
            @(posedge clk);
            waited++;
        end
        checkEqual("commit count", acceptedCount, commitCount);
        @(posedge clk);
    endtask

    initial begin : watchdog
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before all accepted instructions committed");
        $display("Regression failed");
        $fatal(1, "Timeout");
    end

    initial begin
        BackendPkg::ArchIdx prevRd;
        BackendPkg::ArchIdx rd;
        logic [11:0] imm;
        void'($urandom(32'h9804beb6));
        reset = 1'b1;
        fetchValid = 1'b0;
        fetchInst = '0;
        acceptedCount = 0;
        commitCount = 0;
        for (int i = 0; i < `ARCH_REGS; i++) begin
            archRegs[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        testName = "quiet";
        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            checkEqual("stall", 0, stall);
            checkEqual("commitValid", 0, commitValid);
        end
        @(posedge clk);

        testName = "addi";
        for (int n = 0; n < ADDI_COUNT; n++) begin
            imm = 12'($urandom);
            imm[11] = n[0]; // Alternate negative and positive immediates
            sendInst(makeAddi(randReg(), randReg(), imm));
            idleGap();
        end
        drainPipeline();

        testName = "rtype";
        for (int n = 0; n < RTYPE_COUNT; n++) begin
            sendInst(makeRType(randReg(), randReg(), randReg()));
            idleGap();
        end
        drainPipeline();

        // Every instruction reads the previous destination, fetched back to back
        testName = "chain";
        prevRd = randReg();
        for (int n = 0; n < CHAIN_COUNT; n++) begin
            rd = randReg();
            if ($urandom % 2 == 0) begin
                sendInst(makeAddi(rd, prevRd, 12'($urandom)));
            end else begin
                sendInst(makeRType(rd, prevRd, ($urandom % 2 == 0) ? prevRd : randReg()));
            end
            prevRd = rd;
        end
        drainPipeline();

        testName = "burst";
        for (int n = 0; n < BURST_COUNT; n++) begin
            if ($urandom % 4 == 0) begin
                sendInst(makeAddi(randReg(), randReg(), 12'($urandom)));
            end else begin
                sendInst(makeRType(randReg(), randReg(), randReg()));
            end
        end
        drainPipeline();

        testName = "end";
        if (i_Backend.portRules.failCount == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            $display("Port assertions failed %0d times", i_Backend.portRules.failCount);
            $display("Regression failed");
            $fatal(1, "Stopping on assertion failures");
        end
    end
endmodule

//--- tb/Backend_assert.sv
`timescale 1ns/1ps

module PortRules (
    input logic clk,
    input logic reset,
    input logic fetchValid,
    input logic stall,
    input logic commitValid,
    input BackendPkg::ArchIdx commitArchReg
);
    int failCount = 0; // Read by the testbench at the end of the run

    // ======================================================================
    // Port rules
    // ======================================================================

    resetQuiet: assert property (@(posedge clk) reset |=> !commitValid && !stall)
        else begin
            failCount = failCount + 1;
            $error("Commit or stall seen right after a reset edge");
        end

    commitRegKnown: assert property (@(posedge clk) disable iff (reset)
        commitValid |-> !$isunknown(commitArchReg))
        else begin
            failCount = failCount + 1;
            $error("Commit register is unknown while commitValid is high");
        end

    // A stalled word was either just fetched or is still being held
    stallNeedsFetch: assert property (@(posedge clk) disable iff (reset)
        stall |-> $past(fetchValid) || $past(stall))
        else begin
            failCount = failCount + 1;
            $error("Stall raised with no fetched or held word");
        end
endmodule

bind Backend PortRules portRules (
    .clk(clk),
    .reset(reset),
    .fetchValid(fetchValid),
    .stall(stall),
    .commitValid(commitValid),
    .commitArchReg(commitArchReg)
);

//--- verilog/Backend.sv
`timescale 1ns/1ps
`include "backend_cfg.svh"

module Backend (
    input logic clk,
    input logic reset,
    input logic fetchValid,
    input BackendPkg::InstWord fetchInst,
    output logic stall,
    output logic commitValid,
    output BackendPkg::ArchIdx commitArchReg,
    output logic [`XLEN-1:0] commitValue
);
    DecodeRenameIO decRenameIo();
    RenameExecIO renameExecIo();
    RobAllocIO robAllocIo();
    WriteBackIO writeBackIo();
    CommitIO commitIo();

    assign commitValid = commitIo.valid;
    assign commitArchReg = commitIo.rd;

    Decode i_Decode (
        .clk(clk),
        .reset(reset),
        .fetchValid(fetchValid),
        .fetchInst(fetchInst),
        .stall(stall),
        .out(decRenameIo)
    );

    Rename i_Rename (
        .clk(clk),
        .reset(reset),
        .in(decRenameIo),
        .exec(renameExecIo),
        .alloc(robAllocIo),
        .wb(writeBackIo),
        .commit(commitIo)
    );

    ROB i_ROB (
        .clk(clk),
        .reset(reset),
        .alloc(robAllocIo),
        .wb(writeBackIo),
        .commit(commitIo),
        .commitValue(commitValue)
    );

    Execute i_Execute (
        .clk(clk),
        .reset(reset),
        .in(renameExecIo),
        .wb(writeBackIo)
    );
endmodule

//--- verilog/Execute.sv
`timescale 1ns/1ps
`include "backend_cfg.svh"

module Execute (
    input logic clk,
    input logic reset,
    RenameExecIO.exec in,
    WriteBackIO.exec wb
);
    logic [`XLEN-1:0] regFile [`PHYS_REGS];
    logic [`XLEN-1:0] srcA;
    logic [`XLEN-1:0] srcB;
    logic [`XLEN-1:0] result;

    always_comb begin
        srcA = (wb.valid && wb.prd == in.prs1) ? wb.value : regFile[in.prs1];
        if (in.useImm) begin
            srcB = in.imm;
        end else begin
            srcB = (wb.valid && wb.prd == in.prs2) ? wb.value : regFile[in.prs2];
        end
        case (in.op)
            BackendPkg::OP_ADD,
            BackendPkg::OP_ADDI: result = srcA + srcB;
            BackendPkg::OP_SUB:  result = srcA - srcB;
            BackendPkg::OP_AND:  result = srcA & srcB;
            BackendPkg::OP_OR:   result = srcA | srcB;
            BackendPkg::OP_XOR:  result = srcA ^ srcB;
            default:             result = '0;
        endcase
    end

    // ======================================================================
    // Writeback stage
    // ======================================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= in.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in.valid) begin
            wb.prd    <= in.prd;
            wb.robIdx <= in.robIdx;
            wb.value  <= result;
        end
    end

    // File update trails the writeback strobe by one edge
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `PHYS_REGS; i++) begin
                regFile[i] <= '0;
            end
        end else if (wb.valid) begin
            regFile[wb.prd] <= wb.value;
        end
    end
endmodule

//--- verilog/ROB.sv
`timescale 1ns/1ps
`include "backend_cfg.svh"

module ROB (
    input logic clk,
    input logic reset,
    RobAllocIO.rob alloc,
    WriteBackIO.sink wb,
    CommitIO.rob commit,
    output logic [`XLEN-1:0] commitValue
);
    BackendPkg::ArchIdx entryRd [`ROB_SIZE];
    BackendPkg::PhysIdx entryPrd [`ROB_SIZE];
    BackendPkg::PhysIdx entryOldPrd [`ROB_SIZE];
    logic [`XLEN-1:0] entryValue [`ROB_SIZE];
    logic [`ROB_SIZE-1:0] entryDone;
    BackendPkg::RobIdx head;
    BackendPkg::RobIdx tail;
    logic [$clog2(`ROB_SIZE):0] count;
    logic wbHit;

    assign alloc.robIdx = tail;
    assign alloc.full = count == `ROB_SIZE;

    // Tag check against the destination recorded at allocation
    assign wbHit = wb.valid && entryPrd[wb.robIdx] == wb.prd;

    assign commit.valid  = count != 0 && entryDone[head];
    assign commit.rd     = entryRd[head];
    assign commit.oldPrd = entryOldPrd[head];
    assign commitValue   = entryValue[head];

    // ======================================================================
    // Pointers and done flags
    // ======================================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            head      <= '0;
            tail      <= '0;
            count     <= '0;
            entryDone <= '0;
        end else begin
            if (alloc.valid) begin
                entryDone[tail] <= 1'b0;
                tail            <= tail + 1'b1;
            end
            if (wbHit) begin
                entryDone[wb.robIdx] <= 1'b1;
            end
            if (commit.valid) begin
                head <= head + 1'b1;
            end
            if (alloc.valid && !commit.valid) begin
                count <= count + 1'b1;
            end else if (commit.valid && !alloc.valid) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc.valid) begin
            entryRd[tail]     <= alloc.rd;
            entryPrd[tail]    <= alloc.prd;
            entryOldPrd[tail] <= alloc.oldPrd;
        end
        if (wbHit) begin
            entryValue[wb.robIdx] <= wb.value; // Held until the entry commits
        end
    end
endmodule

//--- verilog/Rename.sv
`timescale 1ns/1ps
`include "backend_cfg.svh"

module Rename (
    input logic clk,
    input logic reset,
    DecodeRenameIO.rename in,
    RenameExecIO.rename exec,
    RobAllocIO.rename alloc,
    WriteBackIO.sink wb,
    CommitIO.sink commit
);
    BackendPkg::PhysIdx rat [`ARCH_REGS];
    BackendPkg::PhysIdx freeList [`PHYS_REGS];
    BackendPkg::PhysIdx freeHead;
    BackendPkg::PhysIdx freeTail;
    logic [$clog2(`PHYS_REGS):0] freeCount;
    logic [`PHYS_REGS-1:0] busy;
    BackendPkg::PhysIdx prs1;
    BackendPkg::PhysIdx prs2;
    BackendPkg::PhysIdx newPrd;
    logic src1Ready;
    logic src2Ready;
    logic issue;

    // ======================================================================
    // Lookup and issue gate
    // ======================================================================

    assign prs1 = rat[in.rs1];
    assign prs2 = rat[in.rs2];
    assign newPrd = freeList[freeHead];

    // A writeback in this cycle counts as ready, Execute forwards it
    assign src1Ready = !busy[prs1] || (wb.valid && wb.prd == prs1);
    assign src2Ready = in.useImm || !busy[prs2] || (wb.valid && wb.prd == prs2);

    assign issue = in.valid && src1Ready && src2Ready && freeCount != 0 && !alloc.full;
    assign in.stall = in.valid && !issue;

    assign exec.valid  = issue;
    assign exec.op     = in.op;
    assign exec.prd    = newPrd;
    assign exec.prs1   = prs1;
    assign exec.prs2   = prs2;
    assign exec.imm    = in.imm;
    assign exec.useImm = in.useImm;
    assign exec.robIdx = alloc.robIdx;

    assign alloc.valid  = issue;
    assign alloc.rd     = in.rd;
    assign alloc.prd    = newPrd;
    assign alloc.oldPrd = rat[in.rd]; // Freed once this instruction commits

    // ======================================================================
    // Table updates
    // ======================================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `ARCH_REGS; i++) begin
                rat[i] <= BackendPkg::PhysIdx'(i);
            end
            for (int i = 0; i < `PHYS_REGS - `ARCH_REGS; i++) begin
                freeList[i] <= BackendPkg::PhysIdx'(i + `ARCH_REGS);
            end
            freeHead  <= '0;
            freeTail  <= BackendPkg::PhysIdx'(`PHYS_REGS - `ARCH_REGS);
            freeCount <= ($clog2(`PHYS_REGS)+1)'(`PHYS_REGS - `ARCH_REGS);
            busy      <= '0;
        end else begin
            if (issue) begin
                rat[in.rd] <= newPrd;
                freeHead   <= freeHead + 1'b1;
            end
            if (commit.valid) begin
                freeList[freeTail] <= commit.oldPrd;
                freeTail           <= freeTail + 1'b1;
            end
            if (issue && !commit.valid) begin
                freeCount <= freeCount - 1'b1;
            end else if (commit.valid && !issue) begin
                freeCount <= freeCount + 1'b1;
            end
            if (wb.valid) begin
                busy[wb.prd] <= 1'b0;
            end
            if (issue) begin
                busy[newPrd] <= 1'b1; // Never the register being written back
            end
        end
    end
endmodule

//--- verilog/Decode.sv
`timescale 1ns/1ps
`include "backend_cfg.svh"

module Decode (
    input logic clk,
    input logic reset,
    input logic fetchValid,
    input BackendPkg::InstWord fetchInst,
    output logic stall,
    DecodeRenameIO.decode out
);
    logic isImm;
    BackendPkg::ArchIdx decRd;
    BackendPkg::ArchIdx decRs1;
    BackendPkg::ArchIdx decRs2;
    logic [`XLEN-1:0] decImm;

    assign stall = out.valid & out.stall; // Held word cannot leave this cycle

    always_comb begin
        isImm = fetchInst.r.opcode == BackendPkg::OP_ADDI;
        if (isImm) begin
            decRd  = fetchInst.i.rd;
            decRs1 = fetchInst.i.rs1;
            decRs2 = '0;
            decImm = {{(`XLEN-12){fetchInst.i.imm12[11]}}, fetchInst.i.imm12};
        end else begin
            decRd  = fetchInst.r.rd;
            decRs1 = fetchInst.r.rs1;
            decRs2 = fetchInst.r.rs2;
            decImm = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out.valid <= 1'b0;
        end else if (!stall) begin
            out.valid <= fetchValid;
        end
    end

    always_ff @(posedge clk) begin
        if (fetchValid && !stall) begin
            out.op     <= fetchInst.r.opcode;
            out.rd     <= decRd;
            out.rs1    <= decRs1;
            out.rs2    <= decRs2;
            out.imm    <= decImm;
            out.useImm <= isImm;
        end
    end
endmodule

//--- verilog/BackendIfs.sv
`timescale 1ns/1ps
`include "backend_cfg.svh"

// ======================================================================
// Decode to Rename
// ======================================================================

interface DecodeRenameIO;
    logic valid;
    BackendPkg::OpCode op;
    BackendPkg::ArchIdx rd;
    BackendPkg::ArchIdx rs1;
    BackendPkg::ArchIdx rs2;
    logic [`XLEN-1:0] imm;
    logic useImm;
    logic stall;

    modport decode(output valid, op, rd, rs1, rs2, imm, useImm, input stall);
    modport rename(input valid, op, rd, rs1, rs2, imm, useImm, output stall);
endinterface

interface RenameExecIO;
    logic valid;
    BackendPkg::OpCode op;
    BackendPkg::PhysIdx prd;
    BackendPkg::PhysIdx prs1;
    BackendPkg::PhysIdx prs2;
    logic [`XLEN-1:0] imm;
    logic useImm;
    BackendPkg::RobIdx robIdx;

    modport rename(output valid, op, prd, prs1, prs2, imm, useImm, robIdx);
    modport exec(input valid, op, prd, prs1, prs2, imm, useImm, robIdx);
endinterface

// ======================================================================
// ROB side
// ======================================================================

interface RobAllocIO;
    logic valid;
    BackendPkg::ArchIdx rd;
    BackendPkg::PhysIdx prd;
    BackendPkg::PhysIdx oldPrd;
    BackendPkg::RobIdx robIdx;
    logic full;

    modport rename(output valid, rd, prd, oldPrd, input robIdx, full);
    modport rob(input valid, rd, prd, oldPrd, output robIdx, full);
endinterface

interface WriteBackIO;
    logic valid;
    BackendPkg::PhysIdx prd;
    BackendPkg::RobIdx robIdx;
    logic [`XLEN-1:0] value;

    modport exec(output valid, prd, robIdx, value);
    modport sink(input valid, prd, robIdx, value);
endinterface

interface CommitIO;
    logic valid;
    BackendPkg::ArchIdx rd;
    BackendPkg::PhysIdx oldPrd;

    modport rob(output valid, rd, oldPrd);
    modport sink(input valid, rd, oldPrd);
endinterface

//--- verilog/BackendPkg.sv
`include "backend_cfg.svh"

package BackendPkg;

    typedef enum logic [3:0] {
        OP_ADD  = 4'h0,
        OP_SUB  = 4'h1,
        OP_AND  = 4'h2,
        OP_OR   = 4'h3,
        OP_XOR  = 4'h4,
        OP_ADDI = 4'h5
    } OpCode;

    typedef logic [$clog2(`ARCH_REGS)-1:0] ArchIdx;
    typedef logic [$clog2(`PHYS_REGS)-1:0] PhysIdx;
    typedef logic [$clog2(`ROB_SIZE)-1:0] RobIdx;

    typedef struct packed {
        OpCode       opcode;
        ArchIdx      rd;
        ArchIdx      rs1;
        ArchIdx      rs2;
        logic [18:0] pad;
    } RType;

    typedef struct packed {
        OpCode       opcode;
        ArchIdx      rd;
        ArchIdx      rs1;
        logic [11:0] imm12;
        logic [9:0]  pad;
    } IType;

    // The opcode sits in the same bits in both views and picks one
    typedef union packed {
        RType r;
        IType i;
    } InstWord;

endpackage

//--- verilog/backend_cfg.svh
`ifndef BACKEND_CFG_SVH
`define BACKEND_CFG_SVH

// ======================================================================
// Datapath and storage sizes
// ======================================================================

`define XLEN 32

`define ARCH_REGS 8 // Architectural integer registers

`define PHYS_REGS 16 // Rename pool, twice the architectural file

`define ROB_SIZE 8 // In-flight instructions between issue and commit

`endif
